/* verilog.f */
logic/streamPkg.sv
logic/fifoGauge.sv
logic/scaleStage.sv
logic/windowSum.sv
logic/streamTop.sv
verif/streamTb_chk.sv
verif/streamTb.sv

/* run.sh */
#!/bin/sh
# Builds the stream pipeline testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module streamTb \
  -Mdir "$BUILD_DIR" \
  -o streamSim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/streamSim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi

exit 0

/* verif/streamTb.sv */
// Testbench for streamTop that applies a table of stream phases and checks sums and counters.

`timescale 1ns/1ps

module streamTb;

  localparam int GroupLen   = 4;
  localparam int CountWidth = 16;
  localparam int NumRows    = 6;
  localparam int ResetRow   = 2;   // Stall row that is cut short before the mid-run reset.
  localparam int AbortAt    = 10;  // Samples fed before that reset.
  localparam int BaseSeed   = 32'h9107_076a;

  typedef enum int {sinkReady, sinkRandom, sinkStall} sinkMode;

  typedef struct {
    streamPkg::scaleOp  op;
    streamPkg::sample_t offset;
    int                 num;      // Sample count in multiples of GroupLen.
    int                 seedOff;  // Added to the base seed.
    sinkMode            mode;
    int                 stall;    // Cycles of sink stall.
  } row_t;

  logic                  clk;
  logic                  rst;
  streamPkg::scaleOp     op;
  streamPkg::sample_t    offset;
  streamPkg::sample_t    inDat;
  logic                  inVld;
  logic                  inRdy;
  streamPkg::sum_t       sumDat;
  logic                  sumVld;
  logic                  sumRdy;
  logic [CountWidth-1:0] count;
  logic [CountWidth-1:0] maxCount;

  row_t                  rows[NumRows];
  streamPkg::sum_t       expQ[$];  // Model sums not yet seen.
  streamPkg::sum_t       modelAcc;
  int                    modelIdx;
  int                    seed;
  int                    errors;
  int                    cycles = 0;
  int                    limit;
  int                    stallFed;  // Samples taken while the sink was stalled.
  int                    minPeak;   // Lower bound on maxCount since reset.

  streamTop #(
    .GroupLen   (GroupLen),
    .CountWidth (CountWidth)
  ) dut_i (
    .clk      (clk),
    .rst      (rst),
    .op       (op),
    .offset   (offset),
    .inDat    (inDat),
    .inVld    (inVld),
    .inRdy    (inRdy),
    .sumDat   (sumDat),
    .sumVld   (sumVld),
    .sumRdy   (sumRdy),
    .count    (count),
    .maxCount (maxCount)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period.
  end

  // Ends the run once the cycle limit is reached.
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles.", limit);
      $display("Errors: %0d", errors + 1);
      $display("Simulation failed");
      $finish;
    end
  end

  // *********************************************************************
  // Reference model and compare tasks.
  // *********************************************************************

  function automatic streamPkg::sample_t scaleRef(input streamPkg::scaleOp o,
                                                  input streamPkg::sample_t x,
                                                  input streamPkg::sample_t off);
    streamPkg::sample_t r;
    case (o)
      streamPkg::opNegate:    r = ~x + 16'sd1;  // Wraps at 16 bits.
      streamPkg::opShiftLeft: r = {x[streamPkg::SampleWidth-2:0], 1'b0};
      streamPkg::opAddOffset: r = x + off;
      default:                r = x;
    endcase
    return r;
  endfunction

  task automatic modelAccept(input streamPkg::sample_t x, input row_t r);
    modelAcc = modelAcc + streamPkg::sum_t'(scaleRef(r.op, x, r.offset));  // Sign-extended.
    modelIdx++;
    if (modelIdx == GroupLen) begin
      expQ.push_back(modelAcc);  // Group closed.
      modelAcc = '0;
      modelIdx = 0;
    end
  endtask

  task automatic checkSum(input streamPkg::sum_t exp, input streamPkg::sum_t act);
    if (act !== exp) begin
      errors++;
      $display("Mismatch at %0t: sumDat expected %0d, got %0d", $time, exp, act);
    end
  endtask

  task automatic checkCount(input string name, input logic [CountWidth-1:0] exp,
                            input logic [CountWidth-1:0] act, input bit atLeast);
    if (atLeast && act < exp) begin
      errors++;
      $display("Mismatch at %0t: %s expected at least %0d, got %0d", $time, name, exp, act);
    end else if (!atLeast && act !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  // *********************************************************************
  // Phases.
  // *********************************************************************

  task automatic setRow(input int i, input streamPkg::scaleOp o, input streamPkg::sample_t off,
                        input int n, input int so, input sinkMode m, input int st);
    rows[i].op      = o;
    rows[i].offset  = off;
    rows[i].num     = n;
    rows[i].seedOff = so;
    rows[i].mode    = m;
    rows[i].stall   = st;
  endtask

  // Feeds one row; abortAt above 0 stops after that many samples without draining.
  task automatic runRow(input int r, input int abortAt);
    row_t               cur;
    streamPkg::sample_t nextDat;
    int                 sent;
    int                 sums;
    int                 rnd;
    int                 stallLeft;
    int                 feedTo;
    int                 stallExp;
    cur       = rows[r];
    seed      = BaseSeed + cur.seedOff;
    sent      = 0;
    sums      = 0;
    stallFed  = 0;
    stallLeft = cur.stall;
    feedTo    = (abortAt > 0) ? abortAt : cur.num;
    stallExp  = (cur.num < cur.stall) ? cur.num : cur.stall;
    rnd       = $random(seed);
    nextDat   = rnd[streamPkg::SampleWidth-1:0];
    @(posedge clk);
    op     <= cur.op;  // Static for the whole phase.
    offset <= cur.offset;
    while (sent < feedTo || (abortAt == 0 && expQ.size() != 0)) begin
      @(posedge clk);
      if (inVld && inRdy) begin  // Input transfer.
        modelAccept(nextDat, cur);
        if (!sumRdy) begin
          stallFed++;
        end
        sent++;
        rnd     = $random(seed);
        nextDat = rnd[streamPkg::SampleWidth-1:0];
      end
      if (sumVld && sumRdy) begin  // Output transfer.
        sums++;
        if (expQ.size() == 0) begin
          errors++;
          $display("Unexpected group sum %0d at %0t with no group pending.", sumDat, $time);
        end else begin
          checkSum(expQ.pop_front(), sumDat);
        end
      end
      inVld <= (sent < feedTo);
      inDat <= nextDat;
      case (cur.mode)
        sinkRandom: begin
          rnd    = $random(seed);
          sumRdy <= rnd[0];
        end
        sinkStall: begin
          sumRdy <= (stallLeft <= 0);  // Opens once the stall runs out.
          stallLeft--;
        end
        default: sumRdy <= 1'b1;
      endcase
    end
    inVld <= 1'b0;
    if (abortAt == 0) begin
      checkCount("sum transfers", CountWidth'(cur.num / GroupLen), CountWidth'(sums), 1'b0);
      if (cur.mode == sinkStall) begin
        // Input keeps flowing for the whole stall.
        checkCount("samples fed during stall", CountWidth'(stallExp), CountWidth'(stallFed),
                   1'b0);
        if (stallFed - 6 > minPeak) begin
          minPeak = stallFed - 6;  // Up to 6 samples sit outside the queue.
        end
      end
    end
  endtask

  // Queue drained while the peak holds.
  task automatic checkDrained();
    repeat (2) @(posedge clk);
    checkCount("count", '0, count, 1'b0);
    if (minPeak > 0) begin
      checkCount("maxCount", CountWidth'(minPeak), maxCount, 1'b1);
    end
  endtask

  task automatic checkAfterReset();
    @(posedge clk);
    if (sumVld !== 1'b0) begin
      errors++;
      $display("Mismatch at %0t: sumVld expected 0, got %b", $time, sumVld);
    end
    if (inRdy !== 1'b1) begin
      errors++;
      $display("Mismatch at %0t: inRdy expected 1, got %b", $time, inRdy);
    end
    checkCount("count", '0, count, 1'b0);
    checkCount("maxCount", '0, maxCount, 1'b0);
  endtask

  // *********************************************************************
  // Main sequence.
  // *********************************************************************

  initial begin
    rst      = 1'b1;
    op       = streamPkg::opPass;
    offset   = '0;
    inDat    = '0;
    inVld    = 1'b0;
    sumRdy   = 1'b0;
    errors   = 0;
    seed     = BaseSeed;
    modelAcc = '0;
    modelIdx = 0;
    minPeak  = 0;
    stallFed = 0;

    setRow(0, streamPkg::opPass,      16'sd0,      16,  0, sinkReady,  0);
    setRow(1, streamPkg::opNegate,    16'sd0,      16, 11, sinkReady,  0);
    setRow(2, streamPkg::opNegate,    16'sd0,      24, 64, sinkStall,  40);
    setRow(3, streamPkg::opShiftLeft, 16'sd0,      16, 23, sinkReady,  0);
    setRow(4, streamPkg::opAddOffset, 16'sh7f00,   16, 37, sinkReady,  0);  // Forces wraps.
    setRow(5, streamPkg::opAddOffset, -16'sd300,   40, 51, sinkRandom, 0);

    limit = 200 + 2 * (AbortAt + rows[0].num) + rows[ResetRow].stall;  // Reset replay.
    for (int r = 0; r < NumRows; r++) begin
      limit = limit + 2 * rows[r].num + rows[r].stall;
    end

    repeat (3) @(posedge clk);
    rst <= 1'b0;
    checkAfterReset();

    for (int r = 0; r < NumRows; r++) begin
      runRow(r, 0);
      checkDrained();
    end

    // Cut a stalled stream short and reset in the middle.
    runRow(ResetRow, AbortAt);
    rst <= 1'b1;
    repeat (3) @(posedge clk);
    rst      <= 1'b0;
    modelAcc = '0;
    modelIdx = 0;
    minPeak  = 0;
    expQ.delete();  // Pending groups are gone.
    checkAfterReset();
    runRow(0, 0);
    checkDrained();

    if (expQ.size() != 0) begin
      errors++;
      $display("%0d expected group sums never arrived.", expQ.size());
    end
    errors = errors + dut_i.gauge_i.gaugeChk_i.assertFails
                    + dut_i.window_i.windowChk_i.assertFails;
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : streamTb

/* verif/streamTb_chk.sv */
// Assertion checker bound into the FIFO gauge and the window accumulator to watch handshakes and counters.

`timescale 1ns/1ps

module streamTb_chk #(
  parameter int DatWidth   = 16,    // Width of the watched output data.
  parameter bit IsGauge    = 1'b0,  // Enables the gauge-only checks.
  parameter int CountWidth = 16
) (
  input logic                  clk,
  input logic                  rst,

  // Output stream of the bound block.
  input logic [DatWidth-1:0]   dat,
  input logic                  vld,
  input logic                  rdy,

  // Gauge side, tied off for the accumulator.
  input logic                  inRdy,
  input logic [CountWidth-1:0] count,
  input logic [CountWidth-1:0] maxCount
);

  int assertFails;  // Read by the testbench at the end.

  // *********************************************************************
  // Handshake stability.
  // *********************************************************************

  holdStable: assert property (@(posedge clk) disable iff (rst)
    vld && !rdy |=> vld && $stable(dat))
    else begin
      $error("Output valid dropped or data changed while waiting for ready.");
      assertFails++;
    end

  // *********************************************************************
  // Gauge counters and input ready.
  // *********************************************************************

  generate
    if (IsGauge) begin : gaugeChecks
      countBound: assert property (@(posedge clk) disable iff (rst)
        count <= maxCount)
        else begin
          $error("Gauge count %0d exceeds its peak %0d.", count, maxCount);
          assertFails++;
        end

      alwaysReady: assert property (@(posedge clk) inRdy)  // Gauge never stalls.
        else begin
          $error("Gauge input ready went low.");
          assertFails++;
        end
    end
  endgenerate

endmodule : streamTb_chk

// Gauge output stream plus its counters.
bind fifoGauge streamTb_chk #(
  .DatWidth   (streamPkg::SampleWidth),
  .IsGauge    (1'b1),
  .CountWidth (CountWidth)
) gaugeChk_i (
  .clk      (clk),
  .rst      (rst),
  .dat      (oDat),
  .vld      (oVld),
  .rdy      (oRdy),
  .inRdy    (iRdy),
  .count    (count),
  .maxCount (maxCount)
);

// Sum stream only.
bind windowSum streamTb_chk #(
  .DatWidth (streamPkg::SumWidth),
  .IsGauge  (1'b0)
) windowChk_i (
  .clk      (clk),
  .rst      (rst),
  .dat      (sumDat),
  .vld      (sumVld),
  .rdy      (sumRdy),
  .inRdy    (1'b1),
  .count    ('0),
  .maxCount ('0)
);

/* logic/streamTop.sv */
// Pipeline top that chains scale stage, FIFO gauge and window accumulator for FIFO sizing runs.

`timescale 1ns/1ps

module streamTop #(
  parameter int unsigned GroupLen   = 4,   // Samples per window.
  parameter int unsigned CountWidth = 16   // Gauge counter width.
) (
  input  logic                     clk,
  input  logic                     rst,

  // Static control.
  input  streamPkg::scaleOp        op,
  input  streamPkg::sample_t       offset,

  // Input stream.
  input  streamPkg::sample_t       inDat,
  input  logic                     inVld,
  output logic                     inRdy,

  // Group sums.
  output streamPkg::sum_t          sumDat,
  output logic                     sumVld,
  input  logic                     sumRdy,

  // Gauge readout.
  output logic [CountWidth-1:0]    count,
  output logic [CountWidth-1:0]    maxCount
);

  // *********************************************************************
  // Inner streams.
  // *********************************************************************

  streamPkg::sample_t scaleDat;  // Scale stage to gauge.
  logic               scaleVld;
  logic               scaleRdy;

  streamPkg::sample_t gaugeDat;  // Gauge to accumulator.
  logic               gaugeVld;
  logic               gaugeRdy;

  scaleStage scale_i (
    .clk    (clk),
    .rst    (rst),
    .op     (op),
    .offset (offset),
    .iDat   (inDat),
    .iVld   (inVld),
    .iRdy   (inRdy),
    .oDat   (scaleDat),
    .oVld   (scaleVld),
    .oRdy   (scaleRdy)
  );

  fifoGauge #(
    .CountWidth (CountWidth)
  ) gauge_i (
    .clk      (clk),
    .rst      (rst),
    .iDat     (scaleDat),
    .iVld     (scaleVld),
    .iRdy     (scaleRdy),
    .oDat     (gaugeDat),
    .oVld     (gaugeVld),
    .oRdy     (gaugeRdy),
    .count    (count),
    .maxCount (maxCount)
  );

  windowSum #(
    .GroupLen (GroupLen)
  ) window_i (
    .clk    (clk),
    .rst    (rst),
    .iDat   (gaugeDat),
    .iVld   (gaugeVld),
    .iRdy   (gaugeRdy),
    .sumDat (sumDat),
    .sumVld (sumVld),
    .sumRdy (sumRdy)
  );

endmodule : streamTop

/* logic/windowSum.sv */
// Window accumulator that sums each group of GroupLen samples and holds the total for the sink.

`timescale 1ns/1ps

module windowSum #(
  parameter int unsigned GroupLen = 4
) (
  input  logic                 clk,
  input  logic                 rst,

  // Sample stream.
  input  streamPkg::sample_t   iDat,
  input  logic                 iVld,
  output logic                 iRdy,

  // Sum stream.
  output streamPkg::sum_t      sumDat,
  output logic                 sumVld,
  input  logic                 sumRdy
);

  // Index needs one bit at least, even for single-sample groups.
  localparam int IdxWidth = (GroupLen > 1) ? $clog2(GroupLen) : 1;
  localparam logic [IdxWidth-1:0] LastIdx = IdxWidth'(GroupLen - 1);

  typedef enum logic {
    stAccum,  // Taking samples.
    stHold    // Sum waits for the sink.
  } sumState;

  // *********************************************************************
  // State.
  // *********************************************************************

  sumState                state;
  logic [IdxWidth-1:0]    idx;        // Position in the group.
  streamPkg::sum_t        acc;        // Partial sum.
  streamPkg::sum_t        sampleExt;  // Sign-extended sample.
  logic                   take;
  logic                   lastIn;     // Closing sample of a group.

  assign iRdy   = (state == stAccum);
  assign sumVld = (state == stHold);
  assign take   = iVld && iRdy;
  assign lastIn = (idx == LastIdx);

  assign sampleExt = {{(streamPkg::SumWidth - streamPkg::SampleWidth){iDat[$high(iDat)]}},
                      iDat};

  // *********************************************************************
  // Accumulate and hand over.
  // *********************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= stAccum;
      idx   <= '0;
      acc   <= '0;
    end else begin
      case (state)
        stAccum: begin
          if (take) begin
            if (lastIn) begin
              idx   <= '0;
              acc   <= '0;       // Fresh group.
              state <= stHold;
            end else begin
              idx <= idx + 1'b1;
              acc <= acc + sampleExt;
            end
          end
        end
        stHold: begin
          if (sumRdy) begin
            state <= stAccum;  // Sink took the sum.
          end
        end
        default: begin
          state <= stAccum;
        end
      endcase
    end
  end

  // Total lands here with the closing sample.
  always_ff @(posedge clk) begin
    if (take && lastIn) begin
      sumDat <= acc + sampleExt;
    end
  end

endmodule : windowSum

/* logic/scaleStage.sv */
// Single-register valid/ready stage that applies the selected scale operation to each sample.

`timescale 1ns/1ps

module scaleStage (
  input  logic                 clk,
  input  logic                 rst,

  // Static control.
  input  streamPkg::scaleOp    op,
  input  streamPkg::sample_t   offset,

  // Input stream.
  input  streamPkg::sample_t   iDat,
  input  logic                 iVld,
  output logic                 iRdy,

  // Scaled stream.
  output streamPkg::sample_t   oDat,
  output logic                 oVld,
  input  logic                 oRdy
);

  // *********************************************************************
  // Operation.
  // *********************************************************************

  streamPkg::sample_t result;  // Wraps to the sample width.
  logic               take;    // Input transfer this cycle.

  always_comb begin
    case (op)
      streamPkg::opPass: begin
        result = iDat;
      end
      streamPkg::opNegate: begin
        result = -iDat;  // Most negative value maps to itself.
      end
      streamPkg::opShiftLeft: begin
        result = iDat <<< 1;  // Top bit falls off.
      end
      streamPkg::opAddOffset: begin
        result = iDat + offset;
      end
      default: begin
        result = iDat;
      end
    endcase
  end

  // *********************************************************************
  // Handshake.
  // *********************************************************************

  // Room when the register is empty or being drained.
  assign iRdy = !oVld || oRdy;
  assign take = iVld && iRdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      oVld <= 1'b0;
    end else if (take) begin
      oVld <= 1'b1;  // New result next cycle.
    end else if (oRdy) begin
      oVld <= 1'b0;  // Drained with no refill.
    end
  end

  // Result register, loaded only on a transfer.
  always_ff @(posedge clk) begin
    if (take) begin
      oDat <= result;
    end
  end

endmodule : scaleStage

/* logic/fifoGauge.sv */
// Simulation-only unbounded FIFO that reports its current and peak fill for FIFO sizing.

`timescale 1ns/1ps

module fifoGauge #(
  parameter int unsigned CountWidth = 16
) (
  input  logic                         clk,
  input  logic                         rst,

  // Upstream side, never stalled.
  input  streamPkg::sample_t           iDat,
  input  logic                         iVld,
  output logic                         iRdy,

  // Downstream side, registered.
  output streamPkg::sample_t           oDat,
  output logic                         oVld,
  input  logic                         oRdy,

  // Occupancy gauge.
  output logic [CountWidth-1:0]        count,
  output logic [CountWidth-1:0]        maxCount
);

  // *********************************************************************
  // Storage.
  // *********************************************************************

  streamPkg::sample_t q[$];  // Grows without limit.

  assign iRdy = 1'b1;  // Input is always taken.

  // *********************************************************************
  // Queue, output register and counters.
  // *********************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      q.delete();        // Drop anything buffered.
      oVld     <= 1'b0;
      count    <= '0;
      maxCount <= '0;
    end else begin
      // Every valid input goes to the back.
      if (iVld) begin
        q.push_back(iDat);
      end

      // Size after this cycle's push.
      count <= CountWidth'(q.size());
      if (CountWidth'(q.size()) > maxCount) begin
        maxCount <= CountWidth'(q.size());  // New peak.
      end

      // Refill the output register when empty or being taken.
      if (!oVld || oRdy) begin
        if (q.size() == 0) begin
          oVld <= 1'b0;  // Nothing to offer.
        end else begin
          oVld <= 1'b1;
          oDat <= q.pop_front();  // Oldest item first.
        end
      end
    end
  end

endmodule : fifoGauge

/* logic/streamPkg.sv */
// Shared sample, sum and operation types; every stream block refers to them by scoped name.

package streamPkg;

  // *********************************************************************
  // Sample and sum widths.
  // *********************************************************************

  localparam int SampleWidth = 16;  // Signed input sample.

  // Eight guard bits cover groups of up to 256 samples.
  localparam int SumWidth = SampleWidth + 8;

  typedef logic signed [SampleWidth-1:0] sample_t;
  typedef logic signed [SumWidth-1:0]    sum_t;

  // *********************************************************************
  // Scale stage operations.
  // *********************************************************************

  typedef enum logic [1:0] {
    opPass      = 2'd0,  // Sample unchanged.
    opNegate    = 2'd1,  // Two's complement negate.
    opShiftLeft = 2'd2,  // Multiply by two.
    opAddOffset = 2'd3   // Add the offset input.
  } scaleOp;

endpackage : streamPkg
